//--- Makefile
VERILATOR ?= verilator
TOP       ?= fastFifoTb
FILELIST  ?= fastFifo.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
BIN       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "test: failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "test: no result in $(LOG)"; exit 1; \
	fi
	@echo "test: passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/fastFifoTb.sv
`timescale 1ns/1ps
`include "fastFifo_macros.svh"

module fastFifoTb;
    import fastFifoPkg::*;

    localparam int safeLimit     = (1 << `FAST_FIFO_DEPTH_LOG2) - 2;
    localparam int availBound    = `FAST_FIFO_WRITE_STAGES + `FAST_FIFO_READ_STAGES + 4;
    localparam int drainSettle   = `FAST_FIFO_READ_STAGES + 3;
    localparam int fillCycles    = safeLimit + 10;
    localparam int drainCycles   = 4 * safeLimit;
    localparam int idleCycles    = 8;
    localparam int randomCycles  = 300;
    localparam int afterReset    = 200;
    localparam int plannedCycles = 2 + fillCycles + 2 * (drainCycles + idleCycles)
                                 + randomCycles + 3 + afterReset;
    localparam int timeoutLimit  = 2 * plannedCycles;

    logic       clk = 1'b0;
    logic       reset;
    logic       writeEnable;
    fifoData_t  dataIn;
    logic       grab;
    fifoCount_t usedw;
    logic       dataAvailable;
    fifoData_t  dataOut;

    // Scoreboard and bookkeeping
    logic [31:0] lfsrState   = 32'h50ac;
    fifoData_t   expected [$];
    fifoData_t   headValue   = '0;
    int          sbCount     = 0;
    int          waitCycles  = 0;
    int          quietCycles = 0;
    logic        noWriteYet  = 1'b1;
    int          cycleCount  = 0;
    int          grabsSeen   = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;
    bit          timedOut    = 1'b0;

    always #5 clk = ~clk;

    fastFifo dut_i (
        .clk              (clk),
        .MEMORY_HAS_RESET (reset),
        .writeEnable      (writeEnable),
        .dataIn           (dataIn),
        .usedw            (usedw),
        .grab             (grab),
        .dataAvailable    (dataAvailable),
        .dataOut          (dataOut)
    );

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // Writes stop at the safe fill level, grabs only while data is offered
    task automatic driveCycle(input bit wantWrite, input bit wantGrab);
        logic [31:0] word;
        @(posedge clk);
        #1;
        drawBits(`FAST_FIFO_WIDTH, word);
        writeEnable = wantWrite && (int'(usedw) < safeLimit);
        dataIn      = fifoData_t'(word);
        grab        = wantGrab && dataAvailable;
    endtask

    // Roughly 3 writes in 4 cycles, grabs half the time
    task automatic randomCycle();
        logic [31:0] writePick;
        logic [31:0] grabPick;
        drawBits(2, writePick);
        drawBits(1, grabPick);
        driveCycle(writePick != 0, grabPick[0]);
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        reset       = 1'b1;
        writeEnable = 1'b0;
        grab        = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic drainAll();
        while (sbCount != 0) begin
            driveCycle(1'b0, 1'b1);
        end
        repeat (idleCycles) driveCycle(1'b0, 1'b0);
    endtask

    task automatic reportResult();
        $display("Grabs checked %0d, value errors %0d, other errors %0d",
                 grabsSeen, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0 && !timedOut) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
    endtask

    // Model of the FIFO contents, entry in the output register included
    always @(posedge clk) begin
        int sizeBefore;
        sizeBefore = expected.size();
        if (reset) begin
            expected.delete();
            noWriteYet <= 1'b1;
            waitCycles <= 0;
        end else begin
            if (dataAvailable || sizeBefore == 0) begin
                waitCycles <= 0;
            end else begin
                waitCycles <= waitCycles + 1;
            end
            if (grab && dataAvailable && sizeBefore != 0) begin
                void'(expected.pop_front());
                grabsSeen <= grabsSeen + 1;
            end
            if (writeEnable) begin
                expected.push_back(dataIn);
                noWriteYet <= 1'b0;
            end
        end
        sbCount   <= expected.size();
        headValue <= (expected.size() != 0) ? expected[0] : '0;
        if (reset || writeEnable || grab || expected.size() != 0) begin
            quietCycles <= 0;
        end else begin
            quietCycles <= quietCycles + 1;
        end
    end

    resetClean: assert property (@(posedge clk) disable iff (reset)
        noWriteYet |-> (usedw == '0 && !dataAvailable))
    else begin
        otherErrors++;
        $display("Error at %0t: usedw or dataAvailable not clear after reset", $time);
    end

    grabHasEntry: assert property (@(posedge clk) disable iff (reset)
        (grab && dataAvailable) |-> sbCount != 0)
    else begin
        otherErrors++;
        $display("Error at %0t: data offered but nothing was written", $time);
    end

    headMatch: assert property (@(posedge clk) disable iff (reset)
        (grab && dataAvailable && sbCount != 0) |-> dataOut == headValue)
    else begin
        valueErrors++;
        $display("[FAIL] %0t: dataOut %h, expected %h",
                 $time, $sampled(dataOut), $sampled(headValue));
    end

    // Held entry must not move without a grab
    holdStable: assert property (@(posedge clk) disable iff (reset)
        ($past(dataAvailable) && !$past(grab) && !$past(reset))
            |-> (dataAvailable && dataOut == $past(dataOut)))
    else begin
        otherErrors++;
        $display("Error at %0t: output register changed without a grab", $time);
    end

    usedwBound: assert property (@(posedge clk) disable iff (reset)
        int'(usedw) <= sbCount + 1)
    else begin
        otherErrors++;
        $display("Error at %0t: usedw %0d is above the %0d entries held",
                 $time, $sampled(usedw), $sampled(sbCount));
    end

    drainedZero: assert property (@(posedge clk) disable iff (reset)
        (quietCycles >= drainSettle) |-> usedw == '0)
    else begin
        otherErrors++;
        $display("Error at %0t: usedw did not return to zero after draining", $time);
    end

    availLatency: assert property (@(posedge clk) disable iff (reset)
        waitCycles <= availBound)
    else begin
        otherErrors++;
        $display("Error at %0t: entry waiting but dataAvailable stayed low", $time);
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: run did not finish within %0d cycles", timeoutLimit);
            timedOut = 1'b1;
            reportResult();
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        writeEnable = 1'b0;
        dataIn      = '0;
        grab        = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Fill up to the safe level, head stays in the output register
        repeat (fillCycles) driveCycle(1'b1, 1'b0);
        drainAll();

        repeat (randomCycles) randomCycle();
        // Reset with traffic in flight, memory address must be primed again
        applyReset();
        repeat (afterReset) randomCycle();
        drainAll();

        if (grabsSeen == 0) begin
            otherErrors++;
            $display("Error: no entry was ever read back");
        end
        reportResult();
        $finish;
    end

endmodule

//--- fastFifo.f
+incdir+hw
hw/fastFifoPkg.sv
hw/hyperpipe.sv
hw/fifoController.sv
hw/fifoMemory.sv
hw/fifoOutputReg.sv
hw/fastFifo.sv
bench/fastFifoTb.sv

//--- hw/fastFifo.sv
`timescale 1ns/1ps
`include "fastFifo_macros.svh"

module fastFifo (
    input  logic                    clk,
    input  logic                    MEMORY_HAS_RESET,
    input  logic                    writeEnable,
    input  fastFifoPkg::fifoData_t  dataIn,
    output fastFifoPkg::fifoCount_t usedw,
    input  logic                    grab,
    output logic                    dataAvailable,
    output fastFifoPkg::fifoData_t  dataOut
);
    import fastFifoPkg::*;

    fifoAddr_t    writeAddr;
    fifoAddr_t    nextReadAddr;
    logic         readAddressStall;
    logic         isReading;
    logic         empty;
    logic         readRequest;
    logic         dataValid;
    writeBundle_t writeBundle;
    writeBundle_t writeBundleMem;
    readBundle_t  readBundle;
    readBundle_t  readBundleMem;
    fifoData_t    dataInMem;
    fifoData_t    memData;

    // One extra stage each way covers the memory's own registers
    fifoController #(
        .writeStages (`FAST_FIFO_WRITE_STAGES + 1),
        .readStages  (`FAST_FIFO_READ_STAGES + 1)
    ) controller (
        .clk              (clk),
        .MEMORY_HAS_RESET (MEMORY_HAS_RESET),
        .writeEnable      (writeEnable),
        .readRequest      (readRequest),
        .usedw            (usedw),
        .isReading        (isReading),
        .empty            (empty),
        .writeAddr        (writeAddr),
        .readAddressStall (readAddressStall),
        .nextReadAddr     (nextReadAddr)
    );

    assign writeBundle = '{enable: writeEnable, addr: writeAddr};
    assign readBundle  = '{stall: readAddressStall, addr: nextReadAddr};

    // Write path to the memory
    hyperpipe #(.cycles(`FAST_FIFO_WRITE_STAGES), .payload_t(writeBundle_t)) writePipe (
        .clk (clk), .din (writeBundle), .dout (writeBundleMem)
    );
    hyperpipe #(.cycles(`FAST_FIFO_WRITE_STAGES), .payload_t(fifoData_t)) writeDataPipe (
        .clk (clk), .din (dataIn), .dout (dataInMem)
    );

    // Read address path to the memory
    hyperpipe #(.cycles(`FAST_FIFO_READ_STAGES), .payload_t(readBundle_t)) readPipe (
        .clk (clk), .din (readBundle), .dout (readBundleMem)
    );

    // Read strobe follows the address and the memory output register
    hyperpipe #(.cycles(`FAST_FIFO_READ_STAGES + 1), .payload_t(logic)) validPipe (
        .clk (clk), .din (isReading), .dout (dataValid)
    );

    fifoMemory memory (
        .clk              (clk),
        .MEMORY_HAS_RESET (MEMORY_HAS_RESET),
        .writeEnable      (writeBundleMem.enable),
        .writeAddr        (writeBundleMem.addr),
        .dataIn           (dataInMem),
        .readAddressStall (readBundleMem.stall),
        .readAddr         (readBundleMem.addr),
        .dataOut          (memData)
    );

    fifoOutputReg outputReg (
        .clk              (clk),
        .MEMORY_HAS_RESET (MEMORY_HAS_RESET),
        .fifoEmpty        (empty),
        .dataValid        (dataValid),
        .fifoData         (memData),
        .readRequest      (readRequest),
        .grab             (grab),
        .dataAvailable    (dataAvailable),
        .dataOut          (dataOut)
    );

endmodule

//--- hw/fastFifoPkg.sv
`include "fastFifo_macros.svh"

package fastFifoPkg;

    // Pointer into the array
    typedef logic [`FAST_FIFO_DEPTH_LOG2-1:0] fifoAddr_t;

    // Fill level, same width as a pointer but a distinct quantity
    typedef logic [`FAST_FIFO_DEPTH_LOG2-1:0] fifoCount_t;

    // One stored entry
    typedef logic [`FAST_FIFO_WIDTH-1:0] fifoData_t;

    // Write side of the memory, delayed as one unit
    typedef struct packed {
        logic      enable;
        fifoAddr_t addr;
    } writeBundle_t;

    // Read address port of the memory, delayed as one unit
    typedef struct packed {
        logic      stall;
        fifoAddr_t addr;
    } readBundle_t;

endpackage

//--- hw/fastFifo_macros.svh
`ifndef FAST_FIFO_MACROS_SVH
`define FAST_FIFO_MACROS_SVH

// Address width in bits, array holds 2**N entries
`define FAST_FIFO_DEPTH_LOG2 5

// Entry width in bits
`define FAST_FIFO_WIDTH 16

// Extra register stages on write enable, address and data
`define FAST_FIFO_WRITE_STAGES 1

// Extra register stages on read address and stall
`define FAST_FIFO_READ_STAGES 1

// 1 when the memory read address register has a reset,
// 0 when the controller primes it with address zero instead
`define FAST_FIFO_ADDR_RESETTABLE 0

`endif

//--- hw/fifoController.sv
`timescale 1ns/1ps
`include "fastFifo_macros.svh"

module fifoController #(
    parameter int writeStages = 2,
    parameter int readStages  = 2
) (
    input  logic                    clk,
    input  logic                    MEMORY_HAS_RESET,
    input  logic                    writeEnable,
    input  logic                    readRequest,
    output fastFifoPkg::fifoCount_t usedw,
    output logic                    isReading,
    output logic                    empty,
    output fastFifoPkg::fifoAddr_t  writeAddr,
    output logic                    readAddressStall,
    output fastFifoPkg::fifoAddr_t  nextReadAddr
);
    import fastFifoPkg::*;

    // Without a resettable address register the memory gets primed with 0
    localparam bit        priming      = (`FAST_FIFO_ADDR_RESETTABLE == 0);
    localparam fifoAddr_t readAddrInit = priming ? fifoAddr_t'(0) : fifoAddr_t'(1);

    fifoAddr_t writeAddrNext;
    fifoAddr_t writtenSeen;
    fifoAddr_t readHead;
    fifoAddr_t readHeadNext;
    fifoAddr_t consumedSeen;
    logic      resetSeen;

    // Pointers are built from their next value so the delay lines
    // see the cleared value while reset is still applied
    assign writeAddrNext = MEMORY_HAS_RESET ? fifoAddr_t'(0)
                         : writeAddr + fifoAddr_t'(writeEnable);
    assign readHeadNext  = MEMORY_HAS_RESET ? fifoAddr_t'(0)
                         : readHead + fifoAddr_t'(isReading);

    always_ff @(posedge clk) begin
        writeAddr <= writeAddrNext;
        readHead  <= readHeadNext;
        resetSeen <= MEMORY_HAS_RESET;
    end

    // Entries become readable only once the memory holds them
    hyperpipe #(.cycles(writeStages), .payload_t(fifoAddr_t)) writtenPipe (
        .clk  (clk),
        .din  (writeAddrNext),
        .dout (writtenSeen)
    );

    // Space is freed once the memory read address has moved on
    hyperpipe #(.cycles(readStages), .payload_t(fifoAddr_t)) consumedPipe (
        .clk  (clk),
        .din  (readHeadNext),
        .dout (consumedSeen)
    );

    assign usedw = fifoCount_t'(writeAddr - consumedSeen);

    // Held empty in the cycle after reset, which is also the priming cycle
    assign empty     = (writtenSeen == readHead) || resetSeen;
    assign isReading = readRequest && !empty;

    // Released during reset and one cycle after when priming, so the memory loads address 0
    assign readAddressStall = !(isReading || (priming && (MEMORY_HAS_RESET || resetSeen)));

    // nextReadAddr runs one ahead of the entry the memory presents
    always_ff @(posedge clk) begin
        if (MEMORY_HAS_RESET) begin
            nextReadAddr <= readAddrInit;
        end else if (!readAddressStall) begin
            nextReadAddr <= nextReadAddr + 1'b1;
        end
    end

endmodule

//--- hw/fifoMemory.sv
`timescale 1ns/1ps
`include "fastFifo_macros.svh"

module fifoMemory (
    input  logic                   clk,
    input  logic                   MEMORY_HAS_RESET,
    input  logic                   writeEnable,
    input  fastFifoPkg::fifoAddr_t writeAddr,
    input  fastFifoPkg::fifoData_t dataIn,
    input  logic                   readAddressStall,
    input  fastFifoPkg::fifoAddr_t readAddr,
    output fastFifoPkg::fifoData_t dataOut
);
    import fastFifoPkg::*;

    localparam int depth = 1 << `FAST_FIFO_DEPTH_LOG2;

    fifoData_t mem [depth];
    fifoAddr_t readAddrReg;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= dataIn;
        end
    end

    // Stallable read address, as in block RAM with an address clock enable
    generate
        if (`FAST_FIFO_ADDR_RESETTABLE) begin : addrWithReset
            always_ff @(posedge clk) begin
                if (MEMORY_HAS_RESET) begin
                    readAddrReg <= '0;
                end else if (!readAddressStall) begin
                    readAddrReg <= readAddr;
                end
            end
        end else begin : addrNoReset
            always_ff @(posedge clk) begin
                if (!readAddressStall) begin
                    readAddrReg <= readAddr;
                end
            end
        end
    endgenerate

    // Registered output of the addressed entry
    always_ff @(posedge clk) begin
        dataOut <= mem[readAddrReg];
    end

endmodule

//--- hw/fifoOutputReg.sv
`timescale 1ns/1ps

// Holds the FIFO head so it can be taken with no latency.
// Only one read is in flight at a time, so throughput is low
module fifoOutputReg (
    input  logic                   clk,
    input  logic                   MEMORY_HAS_RESET,
    input  logic                   fifoEmpty,
    input  logic                   dataValid,
    input  fastFifoPkg::fifoData_t fifoData,
    output logic                   readRequest,
    input  logic                   grab,
    output logic                   dataAvailable,
    output fastFifoPkg::fifoData_t dataOut
);

    logic readInFlight;

    // Refill on grab, or when idle after the FIFO ran empty
    assign readRequest = !fifoEmpty && (grab || (!dataAvailable && !readInFlight));

    always_ff @(posedge clk) begin
        if (MEMORY_HAS_RESET) begin
            dataAvailable <= 1'b0;
            readInFlight  <= 1'b0;
        end else begin
            if (readRequest) begin
                readInFlight <= 1'b1;
            end else if (dataValid) begin
                readInFlight <= 1'b0;
            end
            if (grab) begin
                dataAvailable <= 1'b0;
            end else if (dataValid && readInFlight) begin
                dataAvailable <= 1'b1;
            end
        end
    end

    // Stray valids left over from before reset are ignored
    always_ff @(posedge clk) begin
        if (!grab && dataValid && readInFlight) begin
            dataOut <= fifoData;
        end
    end

endmodule

//--- hw/hyperpipe.sv
`timescale 1ns/1ps

// Plain delay line, no reset on the stages
module hyperpipe #(
    parameter int  cycles    = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  payload_t din,
    output payload_t dout
);

    generate
        if (cycles == 0) begin : passThrough
            assign dout = din;
        end else begin : stages
            payload_t stage [cycles];

            always_ff @(posedge clk) begin
                stage[0] <= din;
                for (int i = 1; i < cycles; i++) begin
                    stage[i] <= stage[i-1];
                end
            end

            // Last stage drives the output
            assign dout = stage[cycles-1];
        end
    endgenerate

endmodule
